// File: source/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // datapath and tag sizes
    localparam int xlen     = 32;
    localparam int tag_w    = 6;    // tag 0 is a legal tag

    // station geometry
    localparam int rs_count = 4;
    localparam int rs_depth = 4;    // entries per station
    localparam int rs_idx_w = 2;    // selects one of rs_count stations
    localparam int rs_ent_w = 2;    // selects one of rs_depth entries

    // integer ops handled by the single execution unit
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,  // shift amount from b[4:0]
        alu_srl = 3'd6,
        alu_slt = 3'd7   // signed compare, 0 or 1
    } alu_op_e;

    function automatic logic [xlen-1:0] alu_result(
        input alu_op_e         op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b
    );
        logic [xlen-1:0] res;
        case (op)
            alu_add: res = a + b;
            alu_sub: res = a - b;
            alu_and: res = a & b;
            alu_or:  res = a | b;
            alu_xor: res = a ^ b;
            alu_sll: res = a << b[4:0];
            alu_srl: res = a >> b[4:0];
            alu_slt: res = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// File: source/dispatch_router.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_router (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          flush,           // no accept during flush
    input  wire                          dispatch_valid,
    input  wire [ooo_pkg::rs_count-1:0]  station_full,
    output logic [ooo_pkg::rs_count-1:0] station_load,    // one-hot or zero
    output logic                         dispatch_stall
);

    logic [ooo_pkg::rs_idx_w-1:0] rr_ptr;      // next station to try first
    logic [ooo_pkg::rs_idx_w-1:0] pick_idx;
    logic                         pick_found;  // some station has room
    logic                         accept;

    // first non-full station at or after the pointer
    always_comb begin
        logic [ooo_pkg::rs_idx_w-1:0] cand;
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        cand       = rr_ptr;
        for (int i = 0; i < ooo_pkg::rs_count; i++) begin
            cand = rr_ptr + i[ooo_pkg::rs_idx_w-1:0];  // wraps at rs_count
            if (!pick_found && !station_full[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    assign dispatch_stall = flush | ~pick_found;  // all full, or flushing
    assign accept         = dispatch_valid & ~dispatch_stall;

    always_comb begin
        station_load = '0;
        if (accept) begin
            station_load[pick_idx] = 1'b1;
        end
    end

    // pointer moves past the station just loaded
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (accept) begin
            rr_ptr <= pick_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          flush,         // drops every entry
    input  wire                          load,          // from the router
    input  wire ooo_pkg::alu_op_e        op,
    input  wire [ooo_pkg::tag_w-1:0]     dst_tag,
    input  wire                          src1_ready,
    input  wire [ooo_pkg::tag_w-1:0]     src1_tag,
    input  wire [ooo_pkg::xlen-1:0]      src1_value,
    input  wire                          src2_ready,
    input  wire [ooo_pkg::tag_w-1:0]     src2_tag,
    input  wire [ooo_pkg::xlen-1:0]      src2_value,
    input  wire                          result_valid,  // broadcast snoop
    input  wire [ooo_pkg::tag_w-1:0]     result_tag,
    input  wire [ooo_pkg::xlen-1:0]      result_value,
    input  wire                          grant,         // pops the offered entry
    output logic                         full,
    output logic                         ready,
    output ooo_pkg::alu_op_e             issue_op,
    output logic [ooo_pkg::xlen-1:0]     issue_a,
    output logic [ooo_pkg::xlen-1:0]     issue_b,
    output logic [ooo_pkg::tag_w-1:0]    issue_tag
);

    ////////////////////
    // entry storage, kept compacted so slot 0 is the oldest
    logic [ooo_pkg::rs_depth-1:0] ent_valid;
    logic [ooo_pkg::rs_depth-1:0] ent_fresh;  // loaded at the last edge
    logic [ooo_pkg::rs_depth-1:0] ent_rdy1;
    logic [ooo_pkg::rs_depth-1:0] ent_rdy2;
    ooo_pkg::alu_op_e             ent_op   [ooo_pkg::rs_depth];
    logic [ooo_pkg::tag_w-1:0]    ent_dst  [ooo_pkg::rs_depth];
    logic [ooo_pkg::tag_w-1:0]    ent_tag1 [ooo_pkg::rs_depth];
    logic [ooo_pkg::tag_w-1:0]    ent_tag2 [ooo_pkg::rs_depth];
    logic [ooo_pkg::xlen-1:0]     ent_val1 [ooo_pkg::rs_depth];
    logic [ooo_pkg::xlen-1:0]     ent_val2 [ooo_pkg::rs_depth];

    // sources after snooping the result bus
    logic [ooo_pkg::rs_depth-1:0] wk_rdy1;
    logic [ooo_pkg::rs_depth-1:0] wk_rdy2;
    logic [ooo_pkg::xlen-1:0]     wk_val1  [ooo_pkg::rs_depth];
    logic [ooo_pkg::xlen-1:0]     wk_val2  [ooo_pkg::rs_depth];
    logic                         in_rdy1;
    logic                         in_rdy2;
    logic [ooo_pkg::xlen-1:0]     in_val1;
    logic [ooo_pkg::xlen-1:0]     in_val2;

    logic [ooo_pkg::rs_depth-1:0] eligible;
    logic [ooo_pkg::rs_ent_w-1:0] sel_idx;    // oldest eligible slot
    logic                         pop;
    logic [ooo_pkg::rs_depth-1:0] shift;      // slot takes from the one above
    logic [ooo_pkg::rs_depth-1:0] keep_valid;
    logic [ooo_pkg::rs_depth-1:0] take_new;   // slot receives the load
    logic [ooo_pkg::rs_ent_w-1:0] src_idx  [ooo_pkg::rs_depth];
    logic [ooo_pkg::rs_ent_w-1:0] free_idx;

    ////////////////////
    // wakeup
    always_comb begin
        for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            wk_rdy1[i] = ent_rdy1[i] | (result_valid && ent_tag1[i] == result_tag);
            wk_rdy2[i] = ent_rdy2[i] | (result_valid && ent_tag2[i] == result_tag);
            wk_val1[i] = ent_rdy1[i] ? ent_val1[i] : result_value;
            wk_val2[i] = ent_rdy2[i] ? ent_val2[i] : result_value;
        end
    end

    // same-cycle broadcast caught at load
    assign in_rdy1 = src1_ready | (result_valid && src1_tag == result_tag);
    assign in_rdy2 = src2_ready | (result_valid && src2_tag == result_tag);
    assign in_val1 = src1_ready ? src1_value : result_value;
    assign in_val2 = src2_ready ? src2_value : result_value;

    ////////////////////
    // select and issue
    assign eligible = ent_valid & ent_rdy1 & ent_rdy2 & ~ent_fresh;

    always_comb begin
        sel_idx = '0;
        for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
            if (eligible[i]) sel_idx = i[ooo_pkg::rs_ent_w-1:0];  // lowest wins
        end
    end

    assign ready     = |eligible;
    assign full      = ent_valid[ooo_pkg::rs_depth-1];  // top slot used
    assign pop       = grant & ready;
    assign issue_op  = ent_op[sel_idx];
    assign issue_a   = ent_val1[sel_idx];
    assign issue_b   = ent_val2[sel_idx];
    assign issue_tag = ent_dst[sel_idx];

    // close the gap left by a pop, then append the load
    always_comb begin
        int src;
        free_idx = ooo_pkg::rs_ent_w'(ooo_pkg::rs_depth - 1);
        for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            shift[i]      = pop && (i >= int'(sel_idx));
            src           = (shift[i] && i < ooo_pkg::rs_depth - 1) ? i + 1 : i;
            src_idx[i]    = src[ooo_pkg::rs_ent_w-1:0];
            keep_valid[i] = (shift[i] && i == ooo_pkg::rs_depth - 1) ? 1'b0
                                                                      : ent_valid[src_idx[i]];
        end
        for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
            if (!keep_valid[i]) free_idx = i[ooo_pkg::rs_ent_w-1:0];
        end
        take_new = '0;
        if (load) take_new[free_idx] = 1'b1;  // router only loads when not full
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_fresh <= '0;
            ent_rdy1  <= '0;
            ent_rdy2  <= '0;
        end else if (flush) begin
            ent_valid <= '0;
            ent_fresh <= '0;
        end else begin
            for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
                ent_valid[i] <= keep_valid[i] | take_new[i];
                ent_fresh[i] <= take_new[i];  // not offered until next cycle
                ent_rdy1[i]  <= take_new[i] ? in_rdy1 : wk_rdy1[src_idx[i]];
                ent_rdy2[i]  <= take_new[i] ? in_rdy2 : wk_rdy2[src_idx[i]];
            end
        end
    end

    // payload follows the same move as the control bits
    always_ff @(posedge clock) begin
        for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
            if (take_new[i]) begin
                ent_op[i]   <= op;
                ent_dst[i]  <= dst_tag;
                ent_tag1[i] <= src1_tag;
                ent_tag2[i] <= src2_tag;
                ent_val1[i] <= in_val1;
                ent_val2[i] <= in_val2;
            end else begin
                ent_op[i]   <= ent_op[src_idx[i]];
                ent_dst[i]  <= ent_dst[src_idx[i]];
                ent_tag1[i] <= ent_tag1[src_idx[i]];
                ent_tag2[i] <= ent_tag2[src_idx[i]];
                ent_val1[i] <= wk_val1[src_idx[i]];
                ent_val2[i] <= wk_val2[src_idx[i]];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          flush,          // no grant while flushing
    input  wire [ooo_pkg::rs_count-1:0]  station_ready,
    output logic [ooo_pkg::rs_count-1:0] grant,          // one-hot or zero
    output logic                         grant_valid,
    output logic [ooo_pkg::rs_idx_w-1:0] grant_idx
);

    logic [ooo_pkg::rs_idx_w-1:0] prio;  // highest priority station this cycle

    // scan ready stations starting at prio
    always_comb begin
        logic [ooo_pkg::rs_idx_w-1:0] cand;
        logic                         found;
        found     = 1'b0;
        grant_idx = prio;
        cand      = prio;
        for (int i = 0; i < ooo_pkg::rs_count; i++) begin
            cand = prio + i[ooo_pkg::rs_idx_w-1:0];
            if (!found && station_ready[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
        grant_valid = found & ~flush;
    end

    always_comb begin
        grant = '0;
        if (grant_valid) begin
            grant[grant_idx] = 1'b1;
        end
    end

    // winner drops to lowest priority
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            prio <= '0;
        end else if (grant_valid) begin
            prio <= grant_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          flush,         // kills the result in flight
    input  wire                          grant_valid,
    input  wire ooo_pkg::alu_op_e        op,
    input  wire [ooo_pkg::xlen-1:0]      a,
    input  wire [ooo_pkg::xlen-1:0]      b,
    input  wire [ooo_pkg::tag_w-1:0]     tag,
    output logic                         result_valid,  // one-cycle strobe
    output logic [ooo_pkg::tag_w-1:0]    result_tag,
    output logic [ooo_pkg::xlen-1:0]     result_value
);

    // result bus strobe
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= grant_valid & ~flush;
        end
    end

    // tag and value only move on a grant
    always_ff @(posedge clock) begin
        if (grant_valid) begin
            result_tag   <= tag;
            result_value <= ooo_pkg::alu_result(op, a, b);
        end
    end

endmodule

`default_nettype wire

// File: source/ooo_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_core (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          flush,           // mispredict pulse
    // renamed op from outside, held stable under stall
    input  wire                          dispatch_valid,
    input  wire ooo_pkg::alu_op_e        dispatch_op,
    input  wire [ooo_pkg::tag_w-1:0]     dispatch_tag,
    input  wire                          src1_ready,
    input  wire [ooo_pkg::tag_w-1:0]     src1_tag,
    input  wire [ooo_pkg::xlen-1:0]      src1_value,
    input  wire                          src2_ready,
    input  wire [ooo_pkg::tag_w-1:0]     src2_tag,
    input  wire [ooo_pkg::xlen-1:0]      src2_value,
    output logic                         dispatch_stall,
    // result bus, also the wakeup broadcast
    output logic                         result_valid,
    output logic [ooo_pkg::tag_w-1:0]    result_tag,
    output logic [ooo_pkg::xlen-1:0]     result_value
);

    logic [ooo_pkg::rs_count-1:0] station_load;
    logic [ooo_pkg::rs_count-1:0] station_full;
    logic [ooo_pkg::rs_count-1:0] station_ready;
    logic [ooo_pkg::rs_count-1:0] grant;
    logic                         grant_valid;
    logic [ooo_pkg::rs_idx_w-1:0] grant_idx;

    // per-station issue fields
    ooo_pkg::alu_op_e             rs_op  [ooo_pkg::rs_count];
    logic [ooo_pkg::xlen-1:0]     rs_a   [ooo_pkg::rs_count];
    logic [ooo_pkg::xlen-1:0]     rs_b   [ooo_pkg::rs_count];
    logic [ooo_pkg::tag_w-1:0]    rs_tag [ooo_pkg::rs_count];

    ////////////////////
    // dispatch
    dispatch_router u_router (
        .clock(clock), .rst_n(rst_n), .flush(flush),
        .dispatch_valid(dispatch_valid),
        .station_full(station_full),
        .station_load(station_load),
        .dispatch_stall(dispatch_stall)
    );

    ////////////////////
    // stations, all the same kind
    for (genvar g = 0; g < ooo_pkg::rs_count; g++) begin : g_rs
        reservation_station u_rs (
            .clock(clock), .rst_n(rst_n), .flush(flush),
            .load(station_load[g]),
            .op(dispatch_op), .dst_tag(dispatch_tag),
            .src1_ready(src1_ready), .src1_tag(src1_tag), .src1_value(src1_value),
            .src2_ready(src2_ready), .src2_tag(src2_tag), .src2_value(src2_value),
            .result_valid(result_valid), .result_tag(result_tag),
            .result_value(result_value),
            .grant(grant[g]),
            .full(station_full[g]),
            .ready(station_ready[g]),
            .issue_op(rs_op[g]), .issue_a(rs_a[g]), .issue_b(rs_b[g]),
            .issue_tag(rs_tag[g])
        );
    end

    ////////////////////
    // issue and execute
    issue_select u_select (
        .clock(clock), .rst_n(rst_n), .flush(flush),
        .station_ready(station_ready),
        .grant(grant),
        .grant_valid(grant_valid),
        .grant_idx(grant_idx)
    );

    alu_exec u_alu (
        .clock(clock), .rst_n(rst_n), .flush(flush),
        .grant_valid(grant_valid),
        .op(rs_op[grant_idx]),      // granted station's oldest ready entry
        .a(rs_a[grant_idx]),
        .b(rs_b[grant_idx]),
        .tag(rs_tag[grant_idx]),
        .result_valid(result_valid),
        .result_tag(result_tag),
        .result_value(result_value)
    );

endmodule

`default_nettype wire

// File: testbench/ooo_ref.svh
`ifndef OOO_REF_SVH
`define OOO_REF_SVH

////////////////////
// reference model

// one op worked out from the op rules
function automatic logic [ooo_pkg::xlen-1:0] ref_alu(
    input ooo_pkg::alu_op_e         op,
    input logic [ooo_pkg::xlen-1:0] a,
    input logic [ooo_pkg::xlen-1:0] b
);
    logic [4:0] sh;
    logic       lt;
    sh = b[4:0];  // shifts only see the low five bits
    if (a[ooo_pkg::xlen-1] != b[ooo_pkg::xlen-1]) begin
        lt = a[ooo_pkg::xlen-1];  // signs differ, negative side is smaller
    end else begin
        lt = (a < b);
    end
    case (op)
        ooo_pkg::alu_add: return a + b;
        ooo_pkg::alu_sub: return a - b;
        ooo_pkg::alu_and: return a & b;
        ooo_pkg::alu_or:  return a | b;
        ooo_pkg::alu_xor: return a ^ b;
        ooo_pkg::alu_sll: return a << sh;
        ooo_pkg::alu_srl: return a >> sh;
        ooo_pkg::alu_slt: return {{(ooo_pkg::xlen-1){1'b0}}, lt};
        default:          return '0;
    endcase
endfunction

////////////////////
// scoreboard, indexed by tag
logic                      exp_pending [2**ooo_pkg::tag_w];
logic                      exp_cancel  [2**ooo_pkg::tag_w];  // flushed, must never show up
logic [ooo_pkg::xlen-1:0]  exp_value   [2**ooo_pkg::tag_w];
int                        pending_count = 0;
logic [ooo_pkg::tag_w-1:0] tag_next = '0;

// next tag in turn, wraps long after the old owner retired
function automatic logic [ooo_pkg::tag_w-1:0] alloc_tag();
    logic [ooo_pkg::tag_w-1:0] t;
    t             = tag_next;
    tag_next      = tag_next + 1'b1;
    exp_cancel[t] = 1'b0;
    exp_value[t]  = '0;
    return t;
endfunction

// everything still expected at a flush is dead
task automatic cancel_pending();
    logic [ooo_pkg::tag_w-1:0] k;
    for (int i = 0; i < 2**ooo_pkg::tag_w; i++) begin
        k = i[ooo_pkg::tag_w-1:0];
        if (exp_pending[k]) begin
            exp_pending[k] = 1'b0;
            exp_cancel[k]  = 1'b1;
        end
    end
    pending_count = 0;
endtask

////////////////////
// dispatch driver, starts and ends 1 ns after a rising edge
task automatic send_op(
    input  ooo_pkg::alu_op_e          op,
    input  logic [ooo_pkg::tag_w-1:0] tag,
    input  logic                      r1,
    input  logic [ooo_pkg::tag_w-1:0] t1,
    input  logic [ooo_pkg::xlen-1:0]  v1,
    input  logic                      r2,
    input  logic [ooo_pkg::tag_w-1:0] t2,
    input  logic [ooo_pkg::xlen-1:0]  v2,
    output logic                      stalled
);
    logic [ooo_pkg::xlen-1:0] a;
    logic [ooo_pkg::xlen-1:0] b;
    int                       waited;
    a       = r1 ? v1 : exp_value[t1];  // waiting source takes the producer's value
    b       = r2 ? v2 : exp_value[t2];
    stalled = 1'b0;
    waited  = 0;
    dispatch_valid = 1'b1;
    dispatch_op    = op;
    dispatch_tag   = tag;
    src1_ready     = r1;
    src1_tag       = t1;
    src1_value     = v1;
    src2_ready     = r2;
    src2_tag       = t2;
    src2_value     = v2;
    @(negedge clock);
    while (dispatch_stall && waited < timeout_cycles) begin
        stalled = 1'b1;  // held unchanged
        waited++;
        @(negedge clock);
    end
    if (dispatch_stall) begin
        $display("dispatch of tag %0d was never accepted, still stalled after %0d cycles",
                 tag, waited);
        errors++;
    end else begin
        exp_pending[tag] = 1'b1;  // accepted at the coming edge
        exp_value[tag]   = ref_alu(op, a, b);
        pending_count++;
    end
    @(posedge clock);
    #1;
    dispatch_valid = 1'b0;
endtask

`endif

// File: testbench/tb_ooo_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_issue_core;

    logic                      clock = 1'b0;
    logic                      rst_n;
    logic                      flush;
    logic                      dispatch_valid;
    ooo_pkg::alu_op_e          dispatch_op;
    logic [ooo_pkg::tag_w-1:0] dispatch_tag;
    logic                      src1_ready;
    logic [ooo_pkg::tag_w-1:0] src1_tag;
    logic [ooo_pkg::xlen-1:0]  src1_value;
    logic                      src2_ready;
    logic [ooo_pkg::tag_w-1:0] src2_tag;
    logic [ooo_pkg::xlen-1:0]  src2_value;
    logic                      dispatch_stall;
    logic                      result_valid;
    logic [ooo_pkg::tag_w-1:0] result_tag;
    logic [ooo_pkg::xlen-1:0]  result_value;

    integer seed           = 32'h22f69fd5;
    int     timeout_cycles = 200;  // per wait loop
    int     errors         = 0;
    int     test_base      = 0;    // errors before the current test
    int     tests_run      = 0;
    int     tests_passed   = 0;
    int     results_seen   = 0;

    `include "ooo_ref.svh"

    ooo_issue_core u_dut (
        .clock(clock), .rst_n(rst_n), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_tag(dispatch_tag),
        .src1_ready(src1_ready), .src1_tag(src1_tag), .src1_value(src1_value),
        .src2_ready(src2_ready), .src2_tag(src2_tag), .src2_value(src2_value),
        .dispatch_stall(dispatch_stall),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value)
    );

    always #5 clock = ~clock;  // 100 MHz

    function automatic ooo_pkg::alu_op_e rand_op();
        logic [31:0] r;
        r = $random(seed);
        return ooo_pkg::alu_op_e'(r[2:0]);
    endfunction

    function automatic logic [ooo_pkg::xlen-1:0] rand_val();
        return $random(seed);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    // until every expected tag has come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < timeout_cycles) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (pending_count != 0) begin
            $display("%0d expected results never came out within %0d cycles",
                     pending_count, waited);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_base;
        tests_run++;
        if (n == 0) tests_passed++;
        $display("test %-12s %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
        test_base = errors;
    endtask

    ////////////////////
    // result bus monitor samples mid-cycle
    initial begin : monitor
        forever begin
            @(negedge clock);
            if (rst_n && result_valid) begin
                results_seen++;
                assert (!exp_cancel[result_tag]) else begin
                    $display("tag %0d was flushed but came out on the result bus at %0t",
                             result_tag, $time);
                    errors++;
                end
                assert (exp_pending[result_tag] || exp_cancel[result_tag]) else begin
                    $display("tag %0d came out on the result bus unexpected or twice at %0t",
                             result_tag, $time);
                    errors++;
                end
                if (exp_pending[result_tag]) begin
                    assert (result_value === exp_value[result_tag]) else begin
                        $display("[ERROR] %0t result_value (tag %0d): expected %h, got %h",
                                 $time, result_tag, exp_value[result_tag], result_value);
                        errors++;
                    end
                    exp_pending[result_tag] = 1'b0;
                    pending_count--;
                end
            end
        end
    end

    ////////////////////
    // stimulus
    initial begin : main
        logic [ooo_pkg::tag_w-1:0] t;
        logic [ooo_pkg::tag_w-1:0] p;
        logic [ooo_pkg::tag_w-1:0] w;
        logic [ooo_pkg::tag_w-1:0] prev;
        logic [ooo_pkg::tag_w-1:0] prev2;
        logic [ooo_pkg::xlen-1:0]  a;
        logic [ooo_pkg::xlen-1:0]  b;
        logic [ooo_pkg::xlen-1:0]  c;
        ooo_pkg::alu_op_e          op;
        ooo_pkg::alu_op_e          op2;
        logic                      stalled;
        logic                      any_stall;
        int                        n;
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = ooo_pkg::alu_add;
        dispatch_tag   = '0;
        src1_ready     = 1'b0;
        src1_tag       = '0;
        src1_value     = '0;
        src2_ready     = 1'b0;
        src2_tag       = '0;
        src2_value     = '0;
        for (int i = 0; i < 2**ooo_pkg::tag_w; i++) begin
            t              = i[ooo_pkg::tag_w-1:0];
            exp_pending[t] = 1'b0;
            exp_cancel[t]  = 1'b0;
            exp_value[t]   = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // quiet core after reset with nothing offered
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            assert (result_valid === 1'b0) else begin
                $display("[ERROR] %0t result_valid: expected 0, got %b", $time, result_valid);
                errors++;
            end
            assert (dispatch_stall === 1'b0) else begin
                $display("[ERROR] %0t dispatch_stall: expected 0, got %b", $time, dispatch_stall);
                errors++;
            end
        end
        @(posedge clock);
        #1;
        end_test("reset");

        // lone op lands in the cycle after the second edge past acceptance
        t  = alloc_tag();
        op = rand_op();
        a  = rand_val();
        b  = rand_val();
        send_op(op, t, 1'b1, '0, a, 1'b1, '0, b, stalled);
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!(result_valid && result_tag == t) && n < timeout_cycles);
        if (!(result_valid && result_tag == t)) begin
            $display("tag %0d never came out on the result bus within %0d cycles", t, n);
            errors++;
        end else begin
            assert (n == 3) else begin
                $display("[ERROR] %0t result_valid latency (tag %0d): expected 3, got %0d",
                         $time, t, n);
                errors++;
            end
        end
        @(posedge clock);
        #1;
        for (int i = 0; i < 40; i++) begin
            t  = alloc_tag();
            op = rand_op();
            a  = rand_val();
            b  = rand_val();
            send_op(op, t, 1'b1, '0, a, 1'b1, '0, b, stalled);
        end
        wait_drain();
        end_test("independent");

        // chain where each op reads the previous one and the one before it
        for (int i = 0; i < 8; i++) begin
            t  = alloc_tag();
            op = rand_op();
            a  = rand_val();
            b  = rand_val();
            if (i == 0) begin
                send_op(op, t, 1'b1, '0, a, 1'b1, '0, b, stalled);
            end else if (i == 1) begin
                send_op(op, t, 1'b0, prev, a, 1'b1, '0, b, stalled);
            end else begin
                send_op(op, t, 1'b0, prev, a, 1'b0, prev2, b, stalled);  // both waiting
            end
            prev2 = prev;
            prev  = t;
        end
        wait_drain();
        // dependent offered while its producer is on the bus
        p  = alloc_tag();
        op = rand_op();
        a  = rand_val();
        b  = rand_val();
        send_op(op, p, 1'b1, '0, a, 1'b1, '0, b, stalled);
        idle_cycles(2);
        assert (result_valid && result_tag == p) else begin
            $display("producer tag %0d was not on the result bus when its dependent went in", p);
            errors++;
        end
        t  = alloc_tag();
        op = rand_op();
        b  = rand_val();
        send_op(op, t, 1'b0, p, '0, 1'b1, '0, b, stalled);
        wait_drain();
        end_test("dependent");

        // fifteen waiters plus their producer fill every slot
        p  = alloc_tag();
        op = rand_op();
        a  = rand_val();
        b  = rand_val();
        exp_value[p] = ref_alu(op, a, b);  // waiters need it before p goes in
        any_stall = 1'b0;
        for (int i = 0; i < 15; i++) begin
            t   = alloc_tag();
            op2 = rand_op();
            c   = rand_val();
            send_op(op2, t, 1'b0, p, '0, 1'b1, '0, c, stalled);
            any_stall = any_stall | stalled;
        end
        send_op(op, p, 1'b1, '0, a, 1'b1, '0, b, stalled);
        any_stall = any_stall | stalled;
        assert (!any_stall) else begin
            $display("core stalled before all stations were full");
            errors++;
        end
        t   = alloc_tag();
        op2 = rand_op();
        c   = rand_val();
        send_op(op2, t, 1'b1, '0, c, 1'b0, p, '0, stalled);  // held under stall
        assert (stalled) else begin
            $display("dispatch_stall never rose with all stations full");
            errors++;
        end
        assert (!exp_pending[p]) else begin
            $display("held op was accepted before its producer tag %0d completed", p);
            errors++;
        end
        wait_drain();
        end_test("backpressure");

        // fourteen waiters on a tag nobody makes plus two ready ops fill every slot
        w = alloc_tag();
        for (int i = 0; i < 16; i++) begin
            t  = alloc_tag();
            op = rand_op();
            a  = rand_val();
            b  = rand_val();
            if (i < 14) begin
                send_op(op, t, 1'b0, w, '0, 1'b1, '0, b, stalled);
            end else begin
                send_op(op, t, 1'b1, '0, a, 1'b1, '0, b, stalled);
            end
        end
        assert (dispatch_stall === 1'b1) else begin
            $display("[ERROR] %0t dispatch_stall: expected 1, got %b", $time, dispatch_stall);
            errors++;
        end
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        cancel_pending();
        idle_cycles(12);  // monitor flags any flushed tag
        assert (dispatch_stall === 1'b0) else begin
            $display("[ERROR] %0t dispatch_stall: expected 0, got %b", $time, dispatch_stall);
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            t  = alloc_tag();
            op = rand_op();
            a  = rand_val();
            b  = rand_val();
            send_op(op, t, 1'b1, '0, a, 1'b1, '0, b, stalled);
            prev = t;
        end
        p  = alloc_tag();
        op = rand_op();
        a  = rand_val();
        send_op(op, p, 1'b1, '0, a, 1'b0, prev, '0, stalled);
        wait_drain();
        end_test("flush");

        $display("%0d tests, %0d passed, %0d results checked, %0d errors",
                 tests_run, tests_passed, results_seen, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
source/ooo_pkg.sv
source/dispatch_router.sv
source/reservation_station.sv
source/issue_select.sv
source/alu_exec.sv
source/ooo_issue_core.sv
testbench/tb_ooo_issue_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(wildcard source/*.sv testbench/*.sv testbench/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
